//--- tlcs_exec.f
+incdir+src
src/alu_pkg.sv
src/uop_pkg.sv
src/uop_queue.sv
src/reg_file.sv
src/exec_ctrl.sv
src/alu.sv
src/exec_unit.sv
test/tb_exec_unit.sv

//--- test/tb_exec_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench for the execution subsystem
// credit issuer, register/flag model, in-order wb check
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tlcs_defs.svh"

module tb_exec_unit import alu_pkg::*, uop_pkg::*; ();

    localparam int T1_OPS    = `QUEUE_DEPTH;
    localparam int T2_OPS    = 10;
    localparam int T3_OPS    = 8;
    localparam int T4_OPS    = 12;
    localparam int T5_OPS    = 5;
    localparam int T6_OPS    = 20;
    localparam int OP_CYCLES = 10;      // per micro-op with stalls included
    localparam int LIMIT     = (T1_OPS + T2_OPS + T3_OPS + T4_OPS + T5_OPS + T6_OPS)
                               * OP_CYCLES + 200;   // idle stretches and reset

    logic clk;
    logic rst;
    logic uop_valid;
    uop_t uop;
    logic credit;
    wb_t  wb;

    data_t       ref_regs [`REG_COUNT];  // model registers
    flags_t      ref_flags;
    wb_t         exp_q [$];              // write-backs still owed in issue order
    wb_t         exp_wb;
    data_t       last_data;
    logic        prev_credit;            // credit seen one edge earlier
    logic [31:0] rng_state = 32'ha919_ad7d;
    int          sent, returned, wb_seen;
    int          checks, errors, cycles;

    exec_unit exec_unit_inst (
        .clk, .rst, .uop_valid, .uop, .credit, .wb
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    function logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic data_t width_mask(input width_t w);
        case (w)
            `WIDTH_BYTE: return 32'h0000_00ff;
            `WIDTH_WORD: return 32'h0000_ffff;
            default:     return 32'hffff_ffff;
        endcase
    endfunction

    function automatic int top_bit(input width_t w);
        case (w)
            `WIDTH_BYTE: return 7;
            `WIDTH_WORD: return 15;
            default:     return 31;
        endcase
    endfunction

    function automatic uop_t make_uop(input alu_sel_t sel, input width_t w,
                                      input reg_idx_t dst, input reg_idx_t src,
                                      input logic use_imm, input data_t imm);
        uop_t u;
        u.sel     = sel;
        u.width   = w;
        u.dst     = dst;
        u.src     = src;
        u.use_imm = use_imm;
        u.imm     = imm;
        return u;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // applies one micro-op to the model and returns the write-back it owes
    task automatic model_uop(input uop_t u, output wb_t e);
        data_t       m, a, b, r;
        logic [32:0] full;      // room for the long carry
        logic [4:0]  nib;       // low nibble sum for H
        logic        cin;
        int          top;
        flags_t      f;
        m   = width_mask(u.width);
        top = top_bit(u.width);
        a   = ref_regs[u.dst] & m;
        b   = (u.use_imm ? u.imm : ref_regs[u.src]) & m;
        f   = ref_flags;
        case (u.sel)
            `ALU_ADD, `ALU_ADC: begin
                cin  = (u.sel == `ALU_ADC) && ref_flags[`FLAG_C];
                full = {1'b0, a} + {1'b0, b} + 33'(cin);
                nib  = {1'b0, a[3:0]} + {1'b0, b[3:0]} + 5'(cin);
                r    = full[31:0];
                f[`FLAG_C] = full[top+1];       // carry out of the width
                f[`FLAG_H] = nib[4];
                f[`FLAG_N] = 1'b0;
                f[`FLAG_V] = (a[top] == b[top]) && (r[top] != a[top]);
            end
            `ALU_SUB: begin
                r = a - b;
                f[`FLAG_C] = a < b;             // borrow at width
                f[`FLAG_H] = a[3:0] < b[3:0];
                f[`FLAG_N] = 1'b1;
                f[`FLAG_V] = (a[top] != b[top]) && (r[top] != a[top]);
            end
            `ALU_AND: begin
                r = a & b;
                f = '0;
            end
            `ALU_OR: begin
                r = a | b;
                f = '0;
            end
            `ALU_XOR: begin
                r = a ^ b;
                f = '0;
            end
            default: r = u.imm;     // move keeps the flags
        endcase
        r = r & m;
        if (u.sel != `ALU_MOVE) begin
            f[`FLAG_S] = r[top];
            f[`FLAG_Z] = (r == '0);
        end
        ref_regs[u.dst] = (ref_regs[u.dst] & ~m) | r;   // upper bits survive
        ref_flags       = f;
        e.valid = 1'b1;
        e.dst   = u.dst;
        e.width = u.width;
        e.data  = r;
        e.flags = f;
    endtask

    // issuer waits for credit and drives one cycle at the falling edge
    task automatic send_uop(input uop_t u);
        wb_t e;
        while (`QUEUE_DEPTH + returned - sent <= 0) @(negedge clk);
        model_uop(u, e);
        exp_q.push_back(e);
        uop_valid = 1'b1;
        uop       = u;
        sent++;
        @(negedge clk);
        uop_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("%-24s finished, %0d errors so far", name, errors);
    endtask

    // wb.valid lags its credit pulse by one edge and its pop by two
    always @(posedge clk) begin
        if (rst) begin
            prev_credit = 1'b0;
        end else begin
            if (wb.valid || prev_credit) check_eq("wb.valid", wb.valid, prev_credit);
            if (wb.valid) begin
                wb_seen++;
                last_data = wb.data;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("write-back at %0t with no micro-op outstanding", $time);
                end else begin
                    exp_wb = exp_q.pop_front();
                    check_eq("wb.dst", wb.dst, exp_wb.dst);
                    check_eq("wb.width", wb.width, exp_wb.width);
                    check_eq("wb.data", wb.data, exp_wb.data);
                    check_eq("wb.flags", wb.flags, exp_wb.flags);
                end
            end
            if (credit) begin
                if (returned >= sent) begin
                    errors++;
                    $display("credit pulse at %0t returned more than was sent", $time);
                end
                returned++;
            end
            prev_credit = credit;
        end
    end

    task automatic reset_and_credit();
        repeat (8) @(negedge clk);      // nothing should move yet
        check_eq("credit pulses", returned, 0);
        check_eq("write-backs", wb_seen, 0);
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, reg_idx_t'(i), '0, 1'b1, next_rand()));
        end
        wait_idle();
        check_eq("credit pulses after first ops", returned, `QUEUE_DEPTH);
        report_test("reset and credit");
    endtask

    task automatic add_widths();
        for (int i = 0; i < 4; i++) begin
            send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, reg_idx_t'(i), '0, 1'b1, next_rand()));
        end
        for (int k = 0; k < 6; k++) begin     // byte, word, long twice over
            send_uop(make_uop(`ALU_ADD, width_t'(k % 3), reg_idx_t'(k % 3), 3'd3,
                              1'b0, '0));
        end
        wait_idle();
        report_test("add widths");
    endtask

    task automatic adc_chain();
        send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, 3'd4, '0, 1'b1, 32'h0000_00ff));
        send_uop(make_uop(`ALU_ADD, `WIDTH_BYTE, 3'd4, '0, 1'b1, 32'h0000_0001)); // sets C
        for (int k = 0; k < 6; k++) begin     // all on r4 back to back
            send_uop(make_uop(`ALU_ADC, width_t'(next_rand() % 3), 3'd4, '0, 1'b1,
                              next_rand()));
        end
        wait_idle();
        report_test("adc chain");
    endtask

    task automatic sub_and_logic();
        send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, 3'd1, '0, 1'b1, 32'h0000_0080));
        send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, 3'd2, '0, 1'b1, 32'h0000_0001));
        send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, 3'd5, '0, 1'b1, next_rand()));
        send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, 3'd6, '0, 1'b1, next_rand()));
        send_uop(make_uop(`ALU_SUB, `WIDTH_BYTE, 3'd1, 3'd2, 1'b0, '0));  // 0x80 - 1 sets V
        send_uop(make_uop(`ALU_SUB, `WIDTH_WORD, 3'd2, '0, 1'b1, 32'h2)); // borrows C and H
        send_uop(make_uop(`ALU_SUB, `WIDTH_LONG, 3'd5, 3'd6, 1'b0, '0));
        send_uop(make_uop(`ALU_SUB, `WIDTH_BYTE, 3'd6, '0, 1'b1, next_rand()));
        send_uop(make_uop(`ALU_AND, `WIDTH_LONG, 3'd5, 3'd6, 1'b0, '0));
        send_uop(make_uop(`ALU_OR, `WIDTH_WORD, 3'd6, '0, 1'b1, next_rand()));
        send_uop(make_uop(`ALU_XOR, `WIDTH_BYTE, 3'd1, 3'd5, 1'b0, '0));
        send_uop(make_uop(`ALU_XOR, `WIDTH_LONG, 3'd5, '0, 1'b1, next_rand()));
        wait_idle();
        report_test("sub and logic");
    endtask

    task automatic partial_writes();
        send_uop(make_uop(`ALU_MOVE, `WIDTH_LONG, 3'd7, '0, 1'b1, 32'h1234_5678));
        send_uop(make_uop(`ALU_MOVE, `WIDTH_BYTE, 3'd7, '0, 1'b1, 32'hffff_ffcd));
        send_uop(make_uop(`ALU_ADD, `WIDTH_LONG, 3'd7, '0, 1'b1, '0));
        wait_idle();
        check_eq("r7 after byte write", last_data, 32'h1234_56cd);
        send_uop(make_uop(`ALU_MOVE, `WIDTH_WORD, 3'd7, '0, 1'b1, 32'hffff_abcd));
        send_uop(make_uop(`ALU_ADD, `WIDTH_LONG, 3'd7, '0, 1'b1, '0));
        wait_idle();
        check_eq("r7 after word write", last_data, 32'h1234_abcd);
        report_test("partial writes");
    endtask

    task automatic random_burst();
        int ret0;
        ret0 = returned;
        for (int k = 0; k < T6_OPS; k++) begin
            send_uop(make_uop(alu_sel_t'(next_rand() % 7), width_t'(next_rand() % 3),
                              reg_idx_t'(next_rand()), reg_idx_t'(next_rand()),
                              1'(next_rand()), next_rand()));
        end
        wait_idle();
        check_eq("credit pulses in burst", returned - ret0, T6_OPS);
        report_test("random burst");
    endtask

    initial begin
        rst       = 1'b1;
        uop_valid = 1'b0;
        uop       = '0;
        ref_flags = '0;
        for (int i = 0; i < `REG_COUNT; i++) ref_regs[i] = '0;
        repeat (4) @(negedge clk);     // four cycles of reset
        rst = 1'b0;
        reset_and_credit();
        add_widths();
        adc_chain();
        sub_and_logic();
        partial_writes();
        random_burst();
        $display("checks %0d, errors %0d, micro-ops %0d, write-backs %0d, credits %0d",
                 checks, errors, sent, wb_seen, returned);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles <= LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("run hung: %0d cycles passed with %0d write-backs still expected",
                 cycles, exp_q.size());
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/exec_unit.sv
// ~~~~~~~~~~~~~~~~~~~~
// execution subsystem top: queue,
// issue, register file and ALU
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module exec_unit import alu_pkg::*, uop_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic uop_valid,
    input  uop_t uop,
    output logic credit,
    output wb_t  wb
);

    logic     head_valid;
    uop_t     head;
    logic     pop;
    reg_idx_t rd_idx_a, rd_idx_b;
    data_t    rd_data_a, rd_data_b;
    alu_req_t alu_req;

    uop_queue uop_queue_inst (
        .clk, .rst, .uop_valid, .uop, .pop, .head_valid, .head, .credit
    );

    exec_ctrl exec_ctrl_inst (
        .clk, .rst, .head_valid, .head, .pop,
        .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .wb, .alu_req       // wb fed back for hazards
    );

    reg_file reg_file_inst (
        .clk, .rst, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b, .wb
    );

    alu alu_inst (
        .clk, .rst, .alu_req, .wb
    );

endmodule

`default_nettype wire

//--- src/alu.sv
// ~~~~~~~~~~~~~~~~~~~~
// width-aware ALU with split adder,
// flag register and registered write-back
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tlcs_defs.svh"

module alu import alu_pkg::*, uop_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  alu_req_t alu_req,
    output wb_t      wb
);

    flags_t flags_q;        // architectural status byte
    flags_t flags_nx;
    data_t  addend;         // op2 or its complement
    data_t  sum;
    data_t  res;
    data_t  res_mask;       // bits that belong to the width
    data_t  msb_mask;       // sign bit of the width
    logic   is_sub;
    logic   cin;
    logic   c_nib, c_byte, c_word, c_long;
    logic   c_sel;          // carry out at the selected width
    logic   s_op0, s_op2, s_res;
    logic   z_res;

    assign is_sub = (alu_req.sel == `ALU_SUB);
    assign addend = is_sub ? ~alu_req.op2 : alu_req.op2;   // a - b as a + ~b + 1
    assign cin    = is_sub ? 1'b1 : (alu_req.sel == `ALU_ADC) && flags_q[`FLAG_C];

    // adder split at nibble, byte and word boundaries for H and per-width C
    always_comb begin
        {c_nib,  sum[3:0]}   = {1'b0, alu_req.op0[3:0]}   + {1'b0, addend[3:0]}   + 5'(cin);
        {c_byte, sum[7:4]}   = {1'b0, alu_req.op0[7:4]}   + {1'b0, addend[7:4]}   + 5'(c_nib);
        {c_word, sum[15:8]}  = {1'b0, alu_req.op0[15:8]}  + {1'b0, addend[15:8]}  + 9'(c_byte);
        {c_long, sum[31:16]} = {1'b0, alu_req.op0[31:16]} + {1'b0, addend[31:16]} + 17'(c_word);
    end

    always_comb begin
        case (alu_req.width)
            `WIDTH_BYTE: begin
                res_mask = 32'h0000_00ff;
                c_sel    = c_byte;
            end
            `WIDTH_WORD: begin
                res_mask = 32'h0000_ffff;
                c_sel    = c_word;
            end
            default: begin      // long
                res_mask = 32'hffff_ffff;
                c_sel    = c_long;
            end
        endcase
    end

    always_comb begin
        case (alu_req.sel)
            `ALU_ADD, `ALU_ADC, `ALU_SUB: res = sum;
            `ALU_AND: res = alu_req.op0 & alu_req.op2;
            `ALU_OR:  res = alu_req.op0 | alu_req.op2;
            `ALU_XOR: res = alu_req.op0 ^ alu_req.op2;
            default:  res = alu_req.op2;    // move, immediate through
        endcase
    end

    assign msb_mask = res_mask ^ (res_mask >> 1);
    assign s_op0    = |(alu_req.op0 & msb_mask);
    assign s_op2    = |(alu_req.op2 & msb_mask);   // uncomplemented second operand
    assign s_res    = |(res & msb_mask);
    assign z_res    = (res & res_mask) == '0;

    always_comb begin
        flags_nx = flags_q;     // move leaves flags alone
        case (alu_req.sel)
            `ALU_ADD, `ALU_ADC: begin
                flags_nx[`FLAG_S] = s_res;
                flags_nx[`FLAG_Z] = z_res;
                flags_nx[`FLAG_H] = c_nib;
                flags_nx[`FLAG_V] = (s_op0 == s_op2) && (s_res != s_op0);
                flags_nx[`FLAG_N] = 1'b0;
                flags_nx[`FLAG_C] = c_sel;
            end
            `ALU_SUB: begin
                flags_nx[`FLAG_S] = s_res;
                flags_nx[`FLAG_Z] = z_res;
                flags_nx[`FLAG_H] = ~c_nib;     // borrow from bit 4
                flags_nx[`FLAG_V] = (s_op0 != s_op2) && (s_res != s_op0);
                flags_nx[`FLAG_N] = 1'b1;
                flags_nx[`FLAG_C] = ~c_sel;     // borrow at width
            end
            `ALU_AND, `ALU_OR, `ALU_XOR: begin
                flags_nx          = '0;
                flags_nx[`FLAG_S] = s_res;
                flags_nx[`FLAG_Z] = z_res;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (alu_req.valid) begin
            wb.dst   <= alu_req.dst;
            wb.width <= alu_req.width;
            wb.data  <= res & res_mask;     // zero above the width
            wb.flags <= flags_nx;
        end
        if (rst) begin
            wb.valid <= 1'b0;
            flags_q  <= '0;
        end else begin
            wb.valid <= alu_req.valid;
            if (alu_req.valid) flags_q <= flags_nx;
        end
    end

endmodule

`default_nettype wire

//--- src/exec_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~
// issue stage: hazard check, operand
// read and ALU request register
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tlcs_defs.svh"

module exec_ctrl import alu_pkg::*, uop_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     head_valid,
    input  uop_t     head,
    output logic     pop,
    output reg_idx_t rd_idx_a,
    output reg_idx_t rd_idx_b,
    input  data_t    rd_data_a,
    input  data_t    rd_data_b,
    input  wb_t      wb,
    output alu_req_t alu_req
);

    logic is_move;
    logic need_a;       // dst read as first operand
    logic need_b;       // src read as second operand
    logic busy_a;
    logic busy_b;
    logic hazard;

    // true when idx is still owed a result by the ALU or the wb stage
    function automatic logic in_flight(input reg_idx_t idx, input alu_req_t req,
                                       input wb_t w);
        in_flight = (req.valid && req.dst == idx) || (w.valid && w.dst == idx);
    endfunction

    assign is_move = (head.sel == `ALU_MOVE);
    assign need_a  = !is_move;
    assign need_b  = !head.use_imm;

    assign rd_idx_a = head.dst;
    assign rd_idx_b = head.src;

    assign busy_a = need_a && in_flight(head.dst, alu_req, wb);
    assign busy_b = need_b && in_flight(head.src, alu_req, wb);
    assign hazard = busy_a || busy_b;

    assign pop = head_valid && !hazard;     // stall in place on a hazard

    always_ff @(posedge clk) begin
        if (pop) begin
            alu_req.sel   <= head.sel;
            alu_req.width <= head.width;
            alu_req.dst   <= head.dst;
            alu_req.op0   <= rd_data_a;
            // move always takes the immediate
            alu_req.op2   <= (head.use_imm || is_move) ? head.imm : rd_data_b;
        end
        if (rst) begin
            alu_req.valid <= 1'b0;
        end else begin
            alu_req.valid <= pop;   // bubble when nothing issued
        end
    end

endmodule

`default_nettype wire

//--- src/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// eight-entry register file
// width-masked write, write-first reads
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tlcs_defs.svh"

module reg_file import alu_pkg::*, uop_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    output data_t    rd_data_a,
    output data_t    rd_data_b,
    input  wb_t      wb
);

    data_t regs [`REG_COUNT];
    data_t wr_val;      // destination after the partial write

    // only the low bits of the selected width are replaced
    function automatic data_t merge(input data_t old_val, input data_t new_val,
                                    input width_t w);
        case (w)
            `WIDTH_BYTE: merge = {old_val[`DATA_W-1:8],  new_val[7:0]};
            `WIDTH_WORD: merge = {old_val[`DATA_W-1:16], new_val[15:0]};
            default:     merge = new_val;   // long
        endcase
    endfunction

    assign wr_val = merge(regs[wb.dst], wb.data, wb.width);

    // bypass so a read in the write cycle sees the new value
    assign rd_data_a = (wb.valid && wb.dst == rd_idx_a) ? wr_val : regs[rd_idx_a];
    assign rd_data_b = (wb.valid && wb.dst == rd_idx_b) ? wr_val : regs[rd_idx_b];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dst] <= wr_val;
        end
    end

endmodule

`default_nettype wire

//--- src/uop_queue.sv
// ~~~~~~~~~~~~~~~~~~~~
// micro-op FIFO, show-ahead head,
// one credit pulse per popped entry
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tlcs_defs.svh"

module uop_queue import uop_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic uop_valid,
    input  uop_t uop,
    input  logic pop,
    output logic head_valid,
    output uop_t head,
    output logic credit
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);
    localparam logic [PTR_W-1:0] LAST = PTR_W'(`QUEUE_DEPTH - 1);

    uop_t             mem [`QUEUE_DEPTH];   // payload only, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;                // 0..QUEUE_DEPTH
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        next_ptr = (p == LAST) ? '0 : p + 1'b1;     // wrap for any depth
    endfunction

    assign do_pop     = pop && head_valid;  // ignore pop on empty
    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];        // visible the cycle after the write

    always_ff @(posedge clk) begin
        if (uop_valid) begin
            mem[wr_ptr] <= uop;     // credit rule keeps this from overflowing
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (uop_valid) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)    rd_ptr <= next_ptr(rd_ptr);
            case ({uop_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
            credit <= do_pop;   // entry freed, hand credit back
        end
    end

endmodule

`default_nettype wire

//--- src/uop_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// micro-op stream types: register index,
// issued micro-op and write-back record
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "tlcs_defs.svh"

package uop_pkg;
    import alu_pkg::*;

    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // dst is both first operand and destination, except for move
    typedef struct packed {
        alu_sel_t   sel;
        width_t     width;
        reg_idx_t   dst;
        reg_idx_t   src;
        logic       use_imm;    // second operand from imm instead of src
        data_t      imm;
    } uop_t;

    typedef struct packed {
        logic       valid;
        reg_idx_t   dst;
        width_t     width;      // how many low bits land in dst
        data_t      data;
        flags_t     flags;      // flags after the operation
    } wb_t;

endpackage

`default_nettype wire

//--- src/alu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// ALU data types: operands, flags,
// operation select and the request struct
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "tlcs_defs.svh"

package alu_pkg;

    typedef logic [`DATA_W-1:0] data_t;     // operand or result
    typedef logic [7:0]         flags_t;    // S Z 0 H 0 V N C
    typedef logic [2:0]         alu_sel_t;  // ALU_* codes
    typedef logic [1:0]         width_t;    // WIDTH_* codes

    // one operation handed from issue to the ALU
    typedef struct packed {
        alu_sel_t               sel;
        width_t                 width;
        data_t                  op0;    // register dst contents
        data_t                  op2;    // register src or immediate, already picked
        logic [`REG_IDX_W-1:0]  dst;
        logic                   valid;
    } alu_req_t;

endpackage

`default_nettype wire

//--- src/tlcs_defs.svh
// ~~~~~~~~~~~~~~~~~~~~
// execution subsystem widths, queue depth,
// ALU operation, width and flag encodings
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TLCS_DEFS_SVH
`define TLCS_DEFS_SVH

`define DATA_W      32          // one long word
`define REG_COUNT   8
`define REG_IDX_W   3
`define QUEUE_DEPTH 4           // also the issuer's starting credit

`define ALU_MOVE    3'd0
`define ALU_ADD     3'd1
`define ALU_ADC     3'd2        // add with stored carry
`define ALU_SUB     3'd3
`define ALU_AND     3'd4
`define ALU_OR      3'd5
`define ALU_XOR     3'd6

`define WIDTH_BYTE  2'd0
`define WIDTH_WORD  2'd1
`define WIDTH_LONG  2'd2

// status byte is S Z 0 H 0 V N C
`define FLAG_S      7
`define FLAG_Z      6
`define FLAG_H      4
`define FLAG_V      2
`define FLAG_N      1
`define FLAG_C      0

`endif
